// File: run_sim.sh
#!/bin/sh
# Build and run the SoC control block testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_soc_ctrl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_soc_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "simulation PASSED"
exit 0

// File: sim.f
verilog/soc_ctrl_pkg.sv
verilog/pad_pkg.sv
verilog/apb_reg_decode.sv
verilog/pad_bank.sv
verilog/soc_global_regs.sv
verilog/prdata_mux.sv
verilog/soc_ctrl_top.sv
test/soc_ctrl_props.sv
test/tb_soc_ctrl.sv

// File: test/soc_ctrl_props.sv
`timescale 1ns/1ps

module soc_ctrl_props
   import soc_ctrl_pkg::*;
#(
   parameter int unsigned JTAG_REG_SIZE = 8
)
(
   input logic                     HCLK,
   input logic                     HRESETn,
   input logic                     we_i,
   input reg_addr_e                reg_i,
   input logic                     fc_fetch_en_valid_i,
   input logic                     fc_fetchen_o,
   input logic [JTAG_REG_SIZE-1:0] soc_jtag_reg_o
);

   // side port pulse or FCFETCH write on the edge before
   a_fetchen_source: assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      $changed(fc_fetchen_o) |-> $past(fc_fetch_en_valid_i || (we_i && reg_i == REG_FCFETCH))
   ) else $error("fc_fetchen_o changed with no side port pulse and no FCFETCH write");

   a_jtag_source: assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      $changed(soc_jtag_reg_o) |-> $past(we_i && reg_i == REG_JTAGREG)
   ) else $error("soc_jtag_reg_o changed without a JTAGREG write");

   a_fetchen_reset: assert property (
      @(posedge HCLK) !HRESETn |=> !fc_fetchen_o
   ) else $error("fc_fetchen_o high right after reset");   // fc must stay idle

endmodule

bind soc_global_regs soc_ctrl_props #(
   .JTAG_REG_SIZE (JTAG_REG_SIZE)
) u_props (
   .HCLK                (HCLK),
   .HRESETn             (HRESETn),
   .we_i                (we_i),
   .reg_i               (reg_i),
   .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
   .fc_fetchen_o        (fc_fetchen_o),
   .soc_jtag_reg_o      (soc_jtag_reg_o)
);

// File: test/tb_soc_ctrl.sv
`timescale 1ns/1ps

module tb_soc_ctrl;

   localparam int unsigned APB_ADDR_WIDTH = 12;
   localparam int unsigned NB_CORES       = 4;
   localparam int unsigned NB_CLUSTERS    = 0;
   localparam int unsigned JTAG_REG_SIZE  = 8;
   localparam int unsigned NBIT_PADCFG    = 6;
   localparam int unsigned NB_PADS        = 64;
   localparam int          READY_TIMEOUT  = 16;   // cycles an access may stall

   logic                                HCLK;
   logic                                HRESETn;
   logic [APB_ADDR_WIDTH-1:0]           paddr;
   logic [31:0]                         pwdata;
   logic                                pwrite;
   logic                                psel;
   logic                                penable;
   logic                                bootsel;
   logic                                fetch_valid;
   logic                                fetch_en;
   logic [JTAG_REG_SIZE-1:0]            jtag_in;
   logic [31:0]                         prdata;
   logic                                pready;
   logic                                pslverr;
   logic [NB_PADS-1:0][NBIT_PADCFG-1:0] pad_cfg;
   logic [NB_PADS-1:0][1:0]             pad_mux;
   logic [JTAG_REG_SIZE-1:0]            jtag_out;
   logic [31:0]                         fc_bootaddr;
   logic                                fc_fetchen;

   // reference model of every kept register
   logic [1:0]               mdl_mux [NB_PADS];
   logic [NBIT_PADCFG-1:0]   mdl_cfg [NB_PADS];
   logic [31:0]              mdl_bootaddr;
   logic                     mdl_fetchen;
   logic [31:0]              mdl_corestatus;
   logic [JTAG_REG_SIZE-1:0] mdl_jtag_out;
   logic [JTAG_REG_SIZE-1:0] mdl_jtag_in;     // steady value on the jtag input
   logic                     mdl_bootsel;

   logic [31:0] lcg_state;
   string       cur_test;
   int          n_checks;
   int          n_errors;
   int          n_tests;
   int          test_checks;
   int          test_errors;

   soc_ctrl_top #(
      .APB_ADDR_WIDTH (APB_ADDR_WIDTH),
      .NB_CORES       (NB_CORES),
      .NB_CLUSTERS    (NB_CLUSTERS),
      .JTAG_REG_SIZE  (JTAG_REG_SIZE),
      .NBIT_PADCFG    (NBIT_PADCFG)
   ) u_dut (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .PADDR_i             (paddr),
      .PWDATA_i            (pwdata),
      .PWRITE_i            (pwrite),
      .PSEL_i              (psel),
      .PENABLE_i           (penable),
      .bootsel_i           (bootsel),
      .fc_fetch_en_valid_i (fetch_valid),
      .fc_fetch_en_i       (fetch_en),
      .soc_jtag_reg_i      (jtag_in),
      .PRDATA_o            (prdata),
      .PREADY_o            (pready),
      .PSLVERR_o           (pslverr),
      .pad_cfg_o           (pad_cfg),
      .pad_mux_o           (pad_mux),
      .soc_jtag_reg_o      (jtag_out),
      .fc_bootaddr_o       (fc_bootaddr),
      .fc_fetchen_o        (fc_fetchen)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #50 HCLK = ~HCLK;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic is_mapped(input logic [6:0] idx);
      return (idx <= 7'h02) || (idx >= 7'h04 && idx <= 7'h17) || (idx == 7'h1D) ||
             (idx == 7'h28) || (idx == 7'h30) || (idx == 7'h31);
   endfunction

   // register values after reset
   task automatic model_reset();
      int p;
      for (p = 0; p < NB_PADS; p++)
      begin
         mdl_mux[p] = 2'b00;
         mdl_cfg[p] = '1;
      end
      mdl_bootaddr   = 32'h1A00_0080;
      mdl_fetchen    = 1'b0;
      mdl_corestatus = 32'h0;
      mdl_jtag_out   = '0;
      mdl_jtag_in    = '0;
      mdl_bootsel    = 1'b0;
   endtask

   task automatic model_write(input logic [6:0] idx, input logic [31:0] data);
      int i;
      int base;
      if (idx >= 7'h04 && idx <= 7'h07)
      begin
         base = (int'(idx) - 4) * 16;            // PADFUNn covers pads 16n..16n+15
         for (i = 0; i < 16; i++)
            mdl_mux[base+i] = data[2*i +: 2];
      end
      else if (idx >= 7'h08 && idx <= 7'h17)
      begin
         base = (int'(idx) - 8) * 4;             // four pads per cfg word
         for (i = 0; i < 4; i++)
            mdl_cfg[base+i] = data[8*i +: NBIT_PADCFG];
      end
      else if (idx == 7'h01)
         mdl_bootaddr = data;
      else if (idx == 7'h02)
         mdl_fetchen = data[0];
      else if (idx == 7'h1D)
         mdl_jtag_out = data[JTAG_REG_SIZE-1:0];
      else if (idx == 7'h28)
         mdl_corestatus = data;
   endtask

   function automatic logic [31:0] expected_read(input logic [6:0] idx);
      logic [31:0] val;
      int          i;
      int          base;
      val = 32'h0;
      if (idx >= 7'h04 && idx <= 7'h07)
      begin
         base = (int'(idx) - 4) * 16;
         for (i = 0; i < 16; i++)
            val[2*i +: 2] = mdl_mux[base+i];
      end
      else if (idx >= 7'h08 && idx <= 7'h17)
      begin
         base = (int'(idx) - 8) * 4;
         for (i = 0; i < 4; i++)
            val[8*i +: NBIT_PADCFG] = mdl_cfg[base+i];
      end
      else
      begin
         case (idx)
            7'h00:          val = {16'(NB_CORES), 16'(NB_CLUSTERS)};
            7'h01:          val = mdl_bootaddr;
            7'h1D:          val = {16'h0, mdl_jtag_in, mdl_jtag_out};
            7'h28, 7'h30:   val = mdl_corestatus;
            7'h31:          val = {30'h0, mdl_bootsel, mdl_bootsel};
            default:        val = 32'h0;    // FCFETCH and unmapped read zero
         endcase
      end
      return val;
   endfunction

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      n_checks++;
      if (expected !== actual)
      begin
         n_errors++;
         $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                  cur_test, what, expected, actual);
      end
   endtask

   // setup phase, then access phase until PREADY
   task automatic apb_transfer(input logic is_write, input logic [6:0] idx,
                               input logic [31:0] wdata, output logic [31:0] rdata);
      int waits;
      @(posedge HCLK);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = is_write;
      paddr   = APB_ADDR_WIDTH'({idx, 2'b00});
      pwdata  = wdata;
      @(posedge HCLK);
      #1;
      penable = 1'b1;
      waits   = 0;
      #20;
      while (!pready && waits < READY_TIMEOUT)
      begin
         @(posedge HCLK);
         #20;
         waits++;
      end
      if (!pready)
      begin
         n_errors++;
         $display("ERROR %s: access to index 0x%02h got no PREADY within %0d cycles",
                  cur_test, idx, READY_TIMEOUT);
      end
      compare("PSLVERR_o", 32'h0, 32'(pslverr));   // slave never flags an error
      rdata = prdata;
      @(posedge HCLK);                          // write lands on this edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [6:0] idx, input logic [31:0] data);
      logic [31:0] unused;
      apb_transfer(1'b1, idx, data, unused);
      model_write(idx, data);
   endtask

   task automatic read_and_compare(input logic [6:0] idx);
      logic [31:0] rd;
      apb_transfer(1'b0, idx, 32'h0, rd);
      compare($sformatf("read 0x%02h", idx), expected_read(idx), rd);
   endtask

   task automatic check_pad_outputs();
      int p;
      for (p = 0; p < NB_PADS; p++)
      begin
         compare($sformatf("pad_mux_o[%0d]", p), 32'(mdl_mux[p]), 32'(pad_mux[p]));
         compare($sformatf("pad_cfg_o[%0d]", p), 32'(mdl_cfg[p]), 32'(pad_cfg[p]));
      end
   endtask

   task automatic check_globals();
      compare("fc_bootaddr_o", mdl_bootaddr, fc_bootaddr);
      compare("soc_jtag_reg_o", 32'(mdl_jtag_out), 32'(jtag_out));
      compare("fc_fetchen_o", 32'(mdl_fetchen), 32'(fc_fetchen));
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_checks = n_checks;
      test_errors = n_errors;
   endtask

   task automatic end_test();
      n_tests++;
      $display("test %s: %0d checks, %0d mismatches",
               cur_test, n_checks - test_checks, n_errors - test_errors);
   endtask

   task automatic pulse_fetch(input logic value);
      @(posedge HCLK);
      #1;
      fetch_valid = 1'b1;
      fetch_en    = value;
      @(posedge HCLK);
      #1;
      fetch_valid = 1'b0;
      mdl_fetchen = value;
   endtask

   task automatic reset_values();
      logic [31:0] rd;
      start_test("reset_values");
      apb_transfer(1'b0, 7'h00, 32'h0, rd);
      compare("INFO", 32'h0004_0000, rd);
      apb_transfer(1'b0, 7'h01, 32'h0, rd);
      compare("FCBOOT", 32'h1A00_0080, rd);
      check_globals();
      check_pad_outputs();
      end_test();
   endtask

   task automatic pad_registers();
      logic [6:0] idx;
      int         n;
      start_test("pad_registers");
      for (n = 0; n < 40; n++)
      begin
         idx = 7'(32'd4 + (lcg_next() >> 16) % 32'd20);   // PADFUN0 .. PADCFG15
         apb_write(idx, lcg_next());
         check_pad_outputs();
         read_and_compare(idx);
      end
      end_test();
   endtask

   task automatic global_registers();
      logic [6:0] idx;
      int         n;
      start_test("global_registers");
      for (n = 0; n < 24; n++)
      begin
         case ((lcg_next() >> 16) % 32'd3)
            32'd0:   idx = 7'h01;
            32'd1:   idx = 7'h28;
            default: idx = 7'h1D;
         endcase
         apb_write(idx, lcg_next());
         read_and_compare(idx);
         read_and_compare(7'h30);               // CS_RO mirror
         check_globals();
      end
      end_test();
   endtask

   task automatic fetch_enable();
      start_test("fetch_enable");
      pulse_fetch(1'b1);
      check_globals();
      pulse_fetch(1'b0);
      check_globals();
      apb_write(7'h02, 32'h0000_0001);
      check_globals();
      read_and_compare(7'h02);
      // side port asks for the opposite value during the whole write
      @(posedge HCLK);
      #1;
      fetch_valid = 1'b1;
      fetch_en    = 1'b1;
      apb_write(7'h02, 32'hFFFF_FFFE);
      fetch_valid = 1'b0;
      check_globals();
      @(posedge HCLK);
      #1;
      fetch_valid = 1'b1;
      fetch_en    = 1'b0;
      apb_write(7'h02, 32'h0000_0001);
      fetch_valid = 1'b0;
      check_globals();
      end_test();
   endtask

   task automatic sync_inputs();
      int n;
      start_test("sync_inputs");
      for (n = 0; n < 4; n++)
      begin
         @(posedge HCLK);
         #1;
         jtag_in = JTAG_REG_SIZE'(lcg_next() >> 24);
         bootsel = (n % 2 == 0);
         repeat (3) @(posedge HCLK);
         #1;
         mdl_jtag_in = jtag_in;
         mdl_bootsel = bootsel;
         read_and_compare(7'h1D);
         read_and_compare(7'h31);
      end
      end_test();
   endtask

   task automatic unmapped_access();
      logic [6:0] idx;
      logic [6:0] widx;
      int         n;
      int         tries;
      start_test("unmapped_access");
      for (n = 0; n < 20; n++)
      begin
         idx   = 7'(lcg_next() >> 25);
         tries = 0;
         while (is_mapped(idx) && tries < 64)
         begin
            idx = 7'(lcg_next() >> 25);
            tries++;
         end
         if (is_mapped(idx))
            idx = 7'h03;
         read_and_compare(idx);
         case ((lcg_next() >> 16) % 32'd4)
            32'd2:   widx = 7'h00;              // INFO
            32'd3:   widx = 7'h30;              // CS_RO
            default: widx = idx;
         endcase
         apb_write(widx, lcg_next());
         read_and_compare(7'h00);
         read_and_compare(7'h01);
         read_and_compare(7'h28);
         read_and_compare(7'h1D);
         check_globals();
      end
      check_pad_outputs();
      end_test();
   endtask

   initial
   begin
      HRESETn     = 1'b0;
      paddr       = '0;
      pwdata      = 32'h0;
      pwrite      = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      bootsel     = 1'b0;
      fetch_valid = 1'b0;
      fetch_en    = 1'b0;
      jtag_in     = '0;
      lcg_state   = 32'h521d1741;
      n_checks    = 0;
      n_errors    = 0;
      n_tests     = 0;
      model_reset();
      repeat (4) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;

      reset_values();
      pad_registers();
      global_registers();
      fetch_enable();
      sync_inputs();
      unmapped_access();

      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: verilog/apb_reg_decode.sv
`timescale 1ns/1ps

module apb_reg_decode
   import soc_ctrl_pkg::*;
   import pad_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 12
)
(
   input  logic [APB_ADDR_WIDTH-1:0] PADDR_i,
   input  logic                      PSEL_i,
   input  logic                      PENABLE_i,
   input  logic                      PWRITE_i,
   output reg_addr_e                 reg_o,
   output logic [BANK_W-1:0]         bank_o,
   output pad_word_e                 word_o,
   output logic [NB_PAD_BANKS-1:0]   bank_we_o,
   output logic                      global_we_o
);

   logic [6:0] idx;
   logic [6:0] cfg_idx;
   logic       apb_wr;
   logic       pad_hit;

   assign idx     = PADDR_i[8:2];               // word index
   assign cfg_idx = idx - 7'(REG_PADCFG0);      // 0..15 inside the cfg window
   assign apb_wr  = PSEL_i & PENABLE_i & PWRITE_i;  // access phase only

   always_comb
   begin
      reg_o  = REG_NONE;
      bank_o = '0;
      word_o = WORD_FUN;
      case (idx) inside
         REG_INFO, REG_FCBOOT, REG_FCFETCH, REG_JTAGREG,
         REG_CORESTATUS, REG_CS_RO, REG_BOOTSEL:
            reg_o = reg_addr_e'(idx);
         [REG_PADFUN0:REG_PADFUN3]:
         begin
            reg_o  = reg_addr_e'(idx);
            bank_o = idx[BANK_W-1:0];           // padfun base is bank aligned
            word_o = WORD_FUN;
         end
         [REG_PADCFG0:REG_PADCFG15]:
         begin
            reg_o  = reg_addr_e'(idx);
            bank_o = cfg_idx[CFG_SEL_W +: BANK_W];   // k / 4
            word_o = pad_word_e'(3'(WORD_CFG0) + 3'(cfg_idx[CFG_SEL_W-1:0]));
         end
         default:
         begin
            reg_o = REG_NONE;
         end
      endcase
   end

   assign pad_hit = reg_o inside {[REG_PADFUN0:REG_PADCFG15]};

   // one strobe per bank, only the addressed one fires
   always_comb
   begin
      for (int b = 0; b < NB_PAD_BANKS; b++)
      begin
         bank_we_o[b] = apb_wr & pad_hit & (bank_o == BANK_W'(b));
      end
   end

   // info, cs_ro, bootsel and unmapped codes take no strobe
   assign global_we_o = apb_wr &
                        (reg_o inside {REG_FCBOOT, REG_FCFETCH, REG_JTAGREG, REG_CORESTATUS});

endmodule

// File: verilog/pad_bank.sv
`timescale 1ns/1ps

module pad_bank
   import soc_ctrl_pkg::*;
   import pad_pkg::*;
#(
   parameter int unsigned NBIT_PADCFG = 6
)
(
   input  logic                                         HCLK,
   input  logic                                         HRESETn,
   input  logic                                         we_i,
   input  pad_word_e                                    word_i,
   input  logic [APB_DATA_W-1:0]                        wdata_i,
   output logic [APB_DATA_W-1:0]                        rdata_o,
   output logic [PADS_PER_BANK-1:0][1:0]                pad_mux_o,
   output logic [PADS_PER_BANK-1:0][NBIT_PADCFG-1:0]    pad_cfg_o
);

   logic [PADS_PER_BANK-1:0][1:0]             r_mux;
   logic [PADS_PER_BANK-1:0][NBIT_PADCFG-1:0] r_cfg;
   logic [CFG_SEL_W-1:0]                      cfg_grp;
   logic                                      cfg_hit;

   if (NBIT_PADCFG > PADCFG_SLOT_W || NBIT_PADCFG < 3)
      $error("pad_bank: NBIT_PADCFG must be within 3..8");

   // which group of four pads a cfg word covers
   always_comb
   begin
      cfg_hit = 1'b1;
      case (word_i)
         WORD_CFG0: cfg_grp = CFG_SEL_W'(0);
         WORD_CFG1: cfg_grp = CFG_SEL_W'(1);
         WORD_CFG2: cfg_grp = CFG_SEL_W'(2);
         WORD_CFG3: cfg_grp = CFG_SEL_W'(3);
         default:
         begin
            cfg_hit = 1'b0;
            cfg_grp = '0;
         end
      endcase
   end

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_mux <= '0;
         r_cfg <= '1;                            // pads start fully configured
      end
      else if (we_i)
      begin
         if (word_i == WORD_FUN)
         begin
            for (int i = 0; i < PADS_PER_BANK; i++)
               r_mux[i] <= wdata_i[2*i +: 2];
         end
         else if (cfg_hit)
         begin
            for (int j = 0; j < PADCFG_PER_WORD; j++)
               r_cfg[cfg_grp*PADCFG_PER_WORD + j] <= wdata_i[j*PADCFG_SLOT_W +: NBIT_PADCFG];
         end
      end
   end

   // same layout as the write, spare bits read zero
   always_comb
   begin
      rdata_o = '0;
      if (word_i == WORD_FUN)
      begin
         for (int i = 0; i < PADS_PER_BANK; i++)
            rdata_o[2*i +: 2] = r_mux[i];
      end
      else if (cfg_hit)
      begin
         for (int j = 0; j < PADCFG_PER_WORD; j++)
            rdata_o[j*PADCFG_SLOT_W +: NBIT_PADCFG] = r_cfg[cfg_grp*PADCFG_PER_WORD + j];
      end
   end

   assign pad_mux_o = r_mux;
   assign pad_cfg_o = r_cfg;

endmodule

// File: verilog/pad_pkg.sv
package pad_pkg;

   localparam int unsigned NB_PAD_BANKS    = 4;
   localparam int unsigned PADS_PER_BANK   = 16;
   localparam int unsigned PADCFG_SLOT_W   = 8;   // byte lane per pad
   localparam int unsigned PADCFG_PER_WORD = 4;

   localparam int unsigned CFG_WORDS_PER_BANK = PADS_PER_BANK / PADCFG_PER_WORD;
   localparam int unsigned CFG_SEL_W          = $clog2(CFG_WORDS_PER_BANK);
   localparam int unsigned BANK_W             = $clog2(NB_PAD_BANKS);

   // which word of a bank is addressed
   typedef enum logic [2:0]
   {
      WORD_FUN  = 3'd0,   // two mux bits per pad
      WORD_CFG0 = 3'd1,
      WORD_CFG1 = 3'd2,
      WORD_CFG2 = 3'd3,
      WORD_CFG3 = 3'd4
   } pad_word_e;

endpackage

// File: verilog/prdata_mux.sv
`timescale 1ns/1ps

module prdata_mux
   import soc_ctrl_pkg::*;
   import pad_pkg::*;
#(
   parameter int unsigned NB_CORES      = 4,
   parameter int unsigned NB_CLUSTERS   = 0,
   parameter int unsigned JTAG_REG_SIZE = 8
)
(
   input  reg_addr_e                               reg_i,
   input  logic [BANK_W-1:0]                       bank_i,
   input  logic [NB_PAD_BANKS-1:0][APB_DATA_W-1:0] bank_rdata_i,
   input  logic [APB_DATA_W-1:0]                   global_rdata_i,
   output logic [APB_DATA_W-1:0]                   PRDATA_o
);

   localparam int unsigned HALF_W = APB_DATA_W / 2;

   // output half plus synchronized input half
   localparam logic [APB_DATA_W-1:0] JTAG_MASK = {(2*JTAG_REG_SIZE){1'b1}};

   logic [HALF_W-1:0] n_cores;
   logic [HALF_W-1:0] n_clusters;

   assign n_cores    = HALF_W'(NB_CORES);
   assign n_clusters = HALF_W'(NB_CLUSTERS);

   always_comb
   begin
      case (reg_i) inside
         [REG_PADFUN0:REG_PADCFG15]:
            PRDATA_o = bank_rdata_i[bank_i];      // addressed pad bank
         REG_INFO:
            PRDATA_o = {n_cores, n_clusters};
         REG_JTAGREG:
            PRDATA_o = global_rdata_i & JTAG_MASK;
         REG_NONE:
            PRDATA_o = '0;
         default:
            PRDATA_o = global_rdata_i;
      endcase
   end

endmodule

// File: verilog/soc_ctrl_pkg.sv
package soc_ctrl_pkg;

   localparam int unsigned APB_DATA_W = 32;                // bus word width

   localparam logic [APB_DATA_W-1:0] FC_BOOT_RESET   = 32'h1A00_0080;  // fc boot vector
   localparam logic [APB_DATA_W-1:0] CORESTATUS_RESET = '0;

   // word index taken from PADDR[8:2]
   typedef enum logic [6:0]
   {
      REG_INFO       = 7'h00,   // core and cluster counts
      REG_FCBOOT     = 7'h01,
      REG_FCFETCH    = 7'h02,
      REG_PADFUN0    = 7'h04,   // pads 0..15
      REG_PADFUN1    = 7'h05,
      REG_PADFUN2    = 7'h06,
      REG_PADFUN3    = 7'h07,   // pads 48..63
      REG_PADCFG0    = 7'h08,   // pads 0..3
      REG_PADCFG1    = 7'h09,
      REG_PADCFG2    = 7'h0A,
      REG_PADCFG3    = 7'h0B,
      REG_PADCFG4    = 7'h0C,
      REG_PADCFG5    = 7'h0D,
      REG_PADCFG6    = 7'h0E,
      REG_PADCFG7    = 7'h0F,
      REG_PADCFG8    = 7'h10,
      REG_PADCFG9    = 7'h11,
      REG_PADCFG10   = 7'h12,
      REG_PADCFG11   = 7'h13,
      REG_PADCFG12   = 7'h14,
      REG_PADCFG13   = 7'h15,
      REG_PADCFG14   = 7'h16,
      REG_PADCFG15   = 7'h17,   // pads 60..63
      REG_JTAGREG    = 7'h1D,
      REG_CORESTATUS = 7'h28,   // eoc in bit 31, status below
      REG_CS_RO      = 7'h30,   // read only mirror of corestatus
      REG_BOOTSEL    = 7'h31,
      REG_NONE       = 7'h7F    // any unmapped index
   } reg_addr_e;

endpackage

// File: verilog/soc_ctrl_top.sv
`timescale 1ns/1ps

module soc_ctrl_top
   import soc_ctrl_pkg::*;
   import pad_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 12,
   parameter int unsigned NB_CORES       = 4,
   parameter int unsigned NB_CLUSTERS    = 0,
   parameter int unsigned JTAG_REG_SIZE  = 8,
   parameter int unsigned NBIT_PADCFG    = 6
)
(
   input  logic                                                HCLK,
   input  logic                                                HRESETn,
   input  logic [APB_ADDR_WIDTH-1:0]                           PADDR_i,
   input  logic [APB_DATA_W-1:0]                               PWDATA_i,
   input  logic                                                PWRITE_i,
   input  logic                                                PSEL_i,
   input  logic                                                PENABLE_i,
   input  logic                                                bootsel_i,
   input  logic                                                fc_fetch_en_valid_i,
   input  logic                                                fc_fetch_en_i,
   input  logic [JTAG_REG_SIZE-1:0]                            soc_jtag_reg_i,
   output logic [APB_DATA_W-1:0]                               PRDATA_o,
   output logic                                                PREADY_o,
   output logic                                                PSLVERR_o,
   output logic [NB_PAD_BANKS*PADS_PER_BANK-1:0][NBIT_PADCFG-1:0] pad_cfg_o,
   output logic [NB_PAD_BANKS*PADS_PER_BANK-1:0][1:0]          pad_mux_o,
   output logic [JTAG_REG_SIZE-1:0]                            soc_jtag_reg_o,
   output logic [APB_DATA_W-1:0]                               fc_bootaddr_o,
   output logic                                                fc_fetchen_o
);

   reg_addr_e                               dec_reg;
   logic [BANK_W-1:0]                       dec_bank;
   pad_word_e                               dec_word;
   logic [NB_PAD_BANKS-1:0]                 bank_we;
   logic                                    global_we;
   logic [NB_PAD_BANKS-1:0][APB_DATA_W-1:0] bank_rdata;
   logic [APB_DATA_W-1:0]                   global_rdata;

   apb_reg_decode #(
      .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
   ) u_decode (
      .PADDR_i     (PADDR_i),
      .PSEL_i      (PSEL_i),
      .PENABLE_i   (PENABLE_i),
      .PWRITE_i    (PWRITE_i),
      .reg_o       (dec_reg),
      .bank_o      (dec_bank),
      .word_o      (dec_word),
      .bank_we_o   (bank_we),
      .global_we_o (global_we)
   );

   // bank b drives pads 16*b .. 16*b+15
   for (genvar b = 0; b < NB_PAD_BANKS; b++)
   begin : g_bank
      pad_bank #(
         .NBIT_PADCFG (NBIT_PADCFG)
      ) u_pad_bank (
         .HCLK      (HCLK),
         .HRESETn   (HRESETn),
         .we_i      (bank_we[b]),
         .word_i    (dec_word),
         .wdata_i   (PWDATA_i),
         .rdata_o   (bank_rdata[b]),
         .pad_mux_o (pad_mux_o[b*PADS_PER_BANK +: PADS_PER_BANK]),
         .pad_cfg_o (pad_cfg_o[b*PADS_PER_BANK +: PADS_PER_BANK])
      );
   end

   soc_global_regs #(
      .JTAG_REG_SIZE (JTAG_REG_SIZE)
   ) u_global (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .we_i                (global_we),
      .reg_i               (dec_reg),
      .wdata_i             (PWDATA_i),
      .bootsel_i           (bootsel_i),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .soc_jtag_reg_i      (soc_jtag_reg_i),
      .rdata_o             (global_rdata),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .soc_jtag_reg_o      (soc_jtag_reg_o)
   );

   prdata_mux #(
      .NB_CORES      (NB_CORES),
      .NB_CLUSTERS   (NB_CLUSTERS),
      .JTAG_REG_SIZE (JTAG_REG_SIZE)
   ) u_rdmux (
      .reg_i          (dec_reg),
      .bank_i         (dec_bank),
      .bank_rdata_i   (bank_rdata),
      .global_rdata_i (global_rdata),
      .PRDATA_o       (PRDATA_o)
   );

   assign PREADY_o  = 1'b1;   // zero wait states
   assign PSLVERR_o = 1'b0;

endmodule

// File: verilog/soc_global_regs.sv
`timescale 1ns/1ps

module soc_global_regs
   import soc_ctrl_pkg::*;
#(
   parameter int unsigned JTAG_REG_SIZE = 8
)
(
   input  logic                     HCLK,
   input  logic                     HRESETn,
   input  logic                     we_i,
   input  reg_addr_e                reg_i,
   input  logic [APB_DATA_W-1:0]    wdata_i,
   input  logic                     bootsel_i,
   input  logic                     fc_fetch_en_valid_i,
   input  logic                     fc_fetch_en_i,
   input  logic [JTAG_REG_SIZE-1:0] soc_jtag_reg_i,
   output logic [APB_DATA_W-1:0]    rdata_o,
   output logic [APB_DATA_W-1:0]    fc_bootaddr_o,
   output logic                     fc_fetchen_o,
   output logic [JTAG_REG_SIZE-1:0] soc_jtag_reg_o
);

   logic [APB_DATA_W-1:0]    r_bootaddr;
   logic                     r_fetchen;
   logic [APB_DATA_W-1:0]    r_corestatus;
   logic [JTAG_REG_SIZE-1:0] r_jtag_rego;
   logic [JTAG_REG_SIZE-1:0] r_jtag_meta;   // first sync stage
   logic [JTAG_REG_SIZE-1:0] r_jtag_sync;
   logic [1:0]               r_bootsel;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr   <= FC_BOOT_RESET;
         r_fetchen    <= 1'b0;              // fc stays idle until enabled
         r_corestatus <= CORESTATUS_RESET;
         r_jtag_rego  <= '0;
      end
      else
      begin
         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i;     // side port
         if (we_i)
         begin
            case (reg_i)
               REG_FCBOOT:     r_bootaddr   <= wdata_i;
               REG_FCFETCH:    r_fetchen    <= wdata_i[0];  // apb beats side port
               REG_JTAGREG:    r_jtag_rego  <= wdata_i[JTAG_REG_SIZE-1:0];
               REG_CORESTATUS: r_corestatus <= wdata_i;
               default:        r_corestatus <= r_corestatus;
            endcase
         end
      end
   end

   // two flops on each asynchronous input
   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_jtag_meta <= '0;
         r_jtag_sync <= '0;
         r_bootsel   <= 2'b00;
      end
      else
      begin
         r_jtag_meta <= soc_jtag_reg_i;
         r_jtag_sync <= r_jtag_meta;
         r_bootsel   <= {r_bootsel[0], bootsel_i};   // bit 1 is the older sample
      end
   end

   always_comb
   begin
      rdata_o = '0;
      case (reg_i)
         REG_FCBOOT:
            rdata_o = r_bootaddr;
         REG_CORESTATUS, REG_CS_RO:
            rdata_o = r_corestatus;
         REG_JTAGREG:
         begin
            rdata_o[JTAG_REG_SIZE-1:0]             = r_jtag_rego;
            rdata_o[JTAG_REG_SIZE +: JTAG_REG_SIZE] = r_jtag_sync;   // input half on top
         end
         REG_BOOTSEL:
            rdata_o[1:0] = r_bootsel;
         default:
            rdata_o = '0;
      endcase
   end

   assign fc_bootaddr_o  = r_bootaddr;
   assign fc_fetchen_o   = r_fetchen;
   assign soc_jtag_reg_o = r_jtag_rego;

endmodule
